// ==== files.f ====
+incdir+include
src/fetch_pkg.sv
src/fetch_pc_if.sv
src/fetch_fsm.sv
src/fetch_pc_counter.sv
src/fetch_decode_reg.sv
src/fetch_unit_top.sv
dv/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

export_include_dirs:
  - include

sources:
  - src/fetch_pkg.sv
  - src/fetch_pc_if.sv
  - src/fetch_fsm.sv
  - src/fetch_pc_counter.sv
  - src/fetch_decode_reg.sv
  - src/fetch_unit_top.sv
  - target: test
    files:
      - dv/fetch_tb.sv

// ==== dv/fetch_tb.sv ====
// fetch stage testbench with ibus memory responder, directed and random stimulus and a PC model
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_tb;

   localparam int WAIT_LIMIT = 200;
   localparam logic [31:0] LFSR_SEED = 32'hfcaf71bc;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
   localparam fetch_pkg::insn_t MEM_KEY = 32'ha5c3_0000;

   logic             clk;
   logic             rst;
   logic             ibus_req_o;
   logic             ibus_ack_i;
   logic             ibus_err_i;
   fetch_pkg::insn_t ibus_dat_i;
   logic             padv_i;
   logic             branch_occur_i;
   fetch_pkg::pc_t   branch_dest_i;
   logic             du_restart_i;
   fetch_pkg::pc_t   du_restart_pc_i;
   logic             pipeline_flush_i;
   fetch_pkg::pc_t   pc_addr_o;
   fetch_pkg::pc_t   pc_fetch_o;
   fetch_pkg::pc_t   pc_decode_o;
   fetch_pkg::insn_t decode_insn_o;
   logic             fetch_valid_o;
   logic             fetch_branch_taken_o;
   logic             decode_except_ibus_err_o;

   int          error_count = 0;
   int          check_count = 0;
   logic        flush_arm;
   logic [31:0] stim_lfsr;
   logic [31:0] resp_lfsr;

   fetch_unit_top fetch_unit_top_i (
      .clk                      (clk),
      .rst                      (rst),
      .ibus_req_o               (ibus_req_o),
      .ibus_ack_i               (ibus_ack_i),
      .ibus_err_i               (ibus_err_i),
      .ibus_dat_i               (ibus_dat_i),
      .padv_i                   (padv_i),
      .branch_occur_i           (branch_occur_i),
      .branch_dest_i            (branch_dest_i),
      .du_restart_i             (du_restart_i),
      .du_restart_pc_i          (du_restart_pc_i),
      .pipeline_flush_i         (pipeline_flush_i),
      .pc_addr_o                (pc_addr_o),
      .pc_fetch_o               (pc_fetch_o),
      .pc_decode_o              (pc_decode_o),
      .decode_insn_o            (decode_insn_o),
      .fetch_valid_o            (fetch_valid_o),
      .fetch_branch_taken_o     (fetch_branch_taken_o),
      .decode_except_ibus_err_o (decode_except_ibus_err_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ LFSR_TAPS;
      end
      return state >> 1;
   endfunction

   // one LFSR step per bit taken
   task automatic draw_bits(inout logic [31:0] state, input int nbits,
                            output logic [31:0] value);
      int i;
      value = '0;
      for (i = 0; i < nbits; i++) begin
         value = {value[30:0], state[0]};
         state = lfsr_step(state);
      end
   endtask

   function automatic fetch_pkg::insn_t mem_word(input fetch_pkg::pc_t pc);
      return pc ^ MEM_KEY;
   endfunction

   // addresses that answer with ibus_err_i
   function automatic logic is_err_addr(input fetch_pkg::pc_t pc);
      return (pc == 32'h0000_8000) || (pc == 32'h0000_8008);
   endfunction

   function automatic fetch_pkg::insn_t expected_insn(input fetch_pkg::pc_t pc);
      if (is_err_addr(pc)) begin
         return `FETCH_NOP_INSN;
      end
      return mem_word(pc);
   endfunction

   task automatic check_pc(input string name, input fetch_pkg::pc_t got,
                           input fetch_pkg::pc_t exp);
      check_count++;
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_insn(input string name, input fetch_pkg::insn_t got,
                             input fetch_pkg::insn_t exp);
      check_count++;
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      check_count++;
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
         error_count++;
      end
   endtask

   // ibus memory with 0 to 3 wait states, optional flush on an ack
   initial begin
      logic [31:0]    bits;
      int             wait_left;
      logic           req_prev;
      fetch_pkg::pc_t acc_addr;
      ibus_ack_i       = 1'b0;
      ibus_err_i       = 1'b0;
      ibus_dat_i       = '0;
      pipeline_flush_i = 1'b0;
      resp_lfsr        = LFSR_SEED;
      acc_addr         = '0;
      // move away from the stimulus stream
      draw_bits(resp_lfsr, 16, bits);
      wait_left = -1;
      req_prev  = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         ibus_ack_i       = 1'b0;
         ibus_err_i       = 1'b0;
         pipeline_flush_i = 1'b0;
         if (ibus_req_o && req_prev) begin
            if (wait_left < 0) begin
               draw_bits(resp_lfsr, 2, bits);
               wait_left = int'(bits);
               acc_addr  = pc_fetch_o;
            end else begin
               // the ibus address holds steady until the access completes
               check_pc("pc_fetch_o", pc_fetch_o, acc_addr);
            end
            if (wait_left == 0) begin
               if (is_err_addr(pc_fetch_o)) begin
                  ibus_err_i = 1'b1;
               end else begin
                  ibus_ack_i = 1'b1;
                  ibus_dat_i = mem_word(pc_fetch_o);
               end
               if (flush_arm) begin
                  pipeline_flush_i = 1'b1;
                  flush_arm        = 1'b0;
               end
               wait_left = -1;
            end else begin
               wait_left--;
            end
         end else begin
            wait_left = -1;
         end
         req_prev = ibus_req_o;
      end
   end

   // reference model of the decode stream, sampled mid-cycle
   initial begin
      fetch_pkg::pc_t exp_pc;
      fetch_pkg::pc_t pending_dest;
      logic           branch_pending;
      logic           exp_err;
      logic           padv_prev;
      exp_pc         = `FETCH_RESET_PC;
      pending_dest   = '0;
      branch_pending = 1'b0;
      exp_err        = 1'b0;
      padv_prev      = 1'b1;
      forever begin
         @(negedge clk);
         if (!rst) begin
            if (fetch_valid_o) begin
               if (!padv_prev) begin
                  $display("** Error at %0t ns: valid instruction after a cycle with padv low",
                           $time);
                  error_count++;
               end
               if (fetch_branch_taken_o) begin
                  if (!branch_pending) begin
                     $display("** Error at %0t ns: branch taken flag without a branch", $time);
                     error_count++;
                  end
                  exp_pc         = pending_dest;
                  branch_pending = 1'b0;
               end
               if (is_err_addr(exp_pc)) begin
                  exp_err = 1'b1;
               end
               check_pc("pc_decode_o", pc_decode_o, exp_pc);
               check_insn("decode_insn_o", decode_insn_o, expected_insn(exp_pc));
               check_flag("decode_except_ibus_err_o", decode_except_ibus_err_o, exp_err);
               exp_pc = exp_pc + `FETCH_PC_STEP;
            end else if (fetch_branch_taken_o) begin
               $display("** Error at %0t ns: branch taken flag without a valid", $time);
               error_count++;
            end
            if (branch_occur_i && padv_i) begin
               branch_pending = 1'b1;
               pending_dest   = branch_dest_i;
               exp_err        = 1'b0;
            end
            if (du_restart_i) begin
               exp_pc         = du_restart_pc_i;
               exp_err        = 1'b0;
               branch_pending = 1'b0;
            end
            // the flushed word is skipped for good
            if (pipeline_flush_i && (ibus_ack_i || ibus_err_i)) begin
               exp_pc = exp_pc + `FETCH_PC_STEP;
            end
            padv_prev = padv_i;
         end
      end
   end

   task automatic run_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // returns in the cycle of the matching valid
   task automatic wait_valid(input logic need_taken, input logic match_pc,
                             input fetch_pkg::pc_t pc);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         cycles++;
         seen = fetch_valid_o && (!need_taken || fetch_branch_taken_o) &&
                (!match_pc || pc_decode_o == pc);
      end
      if (!seen) begin
         $display("** Error at %0t ns: timeout, no expected valid within %0d cycles",
                  $time, WAIT_LIMIT);
         error_count++;
      end
   endtask

   task automatic skip_valids(input int n);
      repeat (n) wait_valid(1'b0, 1'b0, '0);
   endtask

   task automatic pulse_branch(input fetch_pkg::pc_t dest);
      branch_dest_i  = dest;
      branch_occur_i = 1'b1;
      run_cycles(1);
      branch_occur_i = 1'b0;
   endtask

   task automatic wait_flush_sent();
      int cycles;
      cycles = 0;
      while (flush_arm && cycles < WAIT_LIMIT) begin
         run_cycles(1);
         cycles++;
      end
      if (flush_arm) begin
         $display("** Error at %0t ns: timeout, flush never met an ibus ack", $time);
         error_count++;
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         $display("%-12s : ok", name);
      end else begin
         $display("%-12s : %0d errors", name, error_count - errors_before);
      end
   endtask

   initial begin
      logic [31:0]    bits;
      fetch_pkg::pc_t dest;
      int             errors_before;
      int             i;
      rst             = 1'b1;
      padv_i          = 1'b1;
      branch_occur_i  = 1'b0;
      branch_dest_i   = `FETCH_RESET_PC;
      du_restart_i    = 1'b0;
      du_restart_pc_i = `FETCH_RESET_PC;
      flush_arm       = 1'b0;
      stim_lfsr       = LFSR_SEED;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      errors_before = error_count;
      check_flag("ibus_req_o", ibus_req_o, 1'b0);
      check_flag("fetch_valid_o", fetch_valid_o, 1'b0);
      check_flag("fetch_branch_taken_o", fetch_branch_taken_o, 1'b0);
      check_flag("decode_except_ibus_err_o", decode_except_ibus_err_o, 1'b0);
      check_pc("pc_addr_o", pc_addr_o, `FETCH_RESET_PC);
      run_cycles(1);
      check_flag("ibus_req_o", ibus_req_o, 1'b1);
      skip_valids(24);
      report_test("sequential", errors_before);

      // random padv low stretches
      errors_before = error_count;
      for (i = 0; i < 12; i++) begin
         draw_bits(stim_lfsr, 3, bits);
         padv_i = 1'b1;
         run_cycles(1 + int'(bits));
         draw_bits(stim_lfsr, 3, bits);
         padv_i = 1'b0;
         run_cycles(1 + int'(bits));
      end
      padv_i = 1'b1;
      skip_valids(4);
      report_test("stall", errors_before);

      errors_before = error_count;
      for (i = 0; i < 4; i++) begin
         wait_valid(1'b0, 1'b0, '0);
         draw_bits(stim_lfsr, 12, bits);
         dest = 32'h0000_1000 + (bits << 2);
         pulse_branch(dest);
         wait_valid(1'b1, 1'b1, dest);
         skip_valids(3);
      end
      report_test("branch", errors_before);

      errors_before = error_count;
      for (i = 0; i < 3; i++) begin
         wait_valid(1'b0, 1'b0, '0);
         flush_arm = 1'b1;
         wait_flush_sent();
         skip_valids(3);
      end
      report_test("flush", errors_before);

      // stream runs across both error words
      errors_before = error_count;
      wait_valid(1'b0, 1'b0, '0);
      pulse_branch(32'h0000_7ff8);
      wait_valid(1'b1, 1'b1, 32'h0000_7ff8);
      wait_valid(1'b0, 1'b1, 32'h0000_8010);
      check_flag("decode_except_ibus_err_o", decode_except_ibus_err_o, 1'b1);
      report_test("bus error", errors_before);

      // restart while the error flag is still set
      errors_before = error_count;
      draw_bits(stim_lfsr, 12, bits);
      dest            = 32'h0000_1000 + (bits << 2);
      du_restart_pc_i = dest;
      du_restart_i    = 1'b1;
      run_cycles(1);
      du_restart_i = 1'b0;
      wait_valid(1'b0, 1'b0, '0);
      check_pc("pc_decode_o", pc_decode_o, dest);
      check_flag("decode_except_ibus_err_o", decode_except_ibus_err_o, 1'b0);
      skip_valids(3);
      report_test("restart", errors_before);

      // set the error flag again, then a taken branch clears it
      errors_before = error_count;
      wait_valid(1'b0, 1'b0, '0);
      pulse_branch(32'h0000_7ffc);
      wait_valid(1'b1, 1'b1, 32'h0000_7ffc);
      wait_valid(1'b0, 1'b1, 32'h0000_800c);
      check_flag("decode_except_ibus_err_o", decode_except_ibus_err_o, 1'b1);
      pulse_branch(32'h0000_2000);
      wait_valid(1'b1, 1'b1, 32'h0000_2000);
      check_flag("decode_except_ibus_err_o", decode_except_ibus_err_o, 1'b0);
      report_test("error clear", errors_before);

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== src/fetch_unit_top.sv ====
// fetch stage top level: instantiate with the ibus and pipeline control on plain ports
`timescale 1ns/1ps

module fetch_unit_top (
   input  logic             clk,
   input  logic             rst,

   // instruction bus, level request with one-cycle ack or err
   output logic             ibus_req_o,
   input  logic             ibus_ack_i,
   input  logic             ibus_err_i,
   input  fetch_pkg::insn_t ibus_dat_i,

   // pipeline control
   input  logic             padv_i,
   input  logic             branch_occur_i,
   input  fetch_pkg::pc_t   branch_dest_i,
   input  logic             du_restart_i,
   input  fetch_pkg::pc_t   du_restart_pc_i,
   input  logic             pipeline_flush_i,

   // lookahead address, one word ahead while streaming
   output fetch_pkg::pc_t   pc_addr_o,
   // ibus address of the access in flight
   output fetch_pkg::pc_t   pc_fetch_o,

   // to decode
   output fetch_pkg::pc_t   pc_decode_o,
   output fetch_pkg::insn_t decode_insn_o,
   output logic             fetch_valid_o,
   output logic             fetch_branch_taken_o,
   output logic             decode_except_ibus_err_o
);

   logic capture;
   logic err_clear_on_branch;

   fetch_pc_if pc_if ();

   assign pc_addr_o  = pc_if.pc_addr;
   assign pc_fetch_o = pc_if.pc_fetch;

   fetch_fsm fetch_fsm_i (
      .clk                  (clk),
      .rst                  (rst),
      .padv_i               (padv_i),
      .branch_occur_i       (branch_occur_i),
      .du_restart_i         (du_restart_i),
      .pipeline_flush_i     (pipeline_flush_i),
      .ibus_ack_i           (ibus_ack_i),
      .ibus_err_i           (ibus_err_i),
      .ibus_req_o           (ibus_req_o),
      .fetch_valid_o        (fetch_valid_o),
      .fetch_branch_taken_o (fetch_branch_taken_o),
      .capture_o            (capture),
      .err_clear_o          (err_clear_on_branch),
      .pc_bus               (pc_if.ctrl)
   );

   fetch_pc_counter fetch_pc_counter_i (
      .clk             (clk),
      .rst             (rst),
      .branch_dest_i   (branch_dest_i),
      .du_restart_pc_i (du_restart_pc_i),
      .pc_bus          (pc_if.pc)
   );

   fetch_decode_reg fetch_decode_reg_i (
      .clk                      (clk),
      .rst                      (rst),
      .capture_i                (capture),
      .ibus_ack_i               (ibus_ack_i),
      .ibus_err_i               (ibus_err_i),
      .du_restart_i             (du_restart_i),
      .err_clear_i              (err_clear_on_branch),
      .ibus_dat_i               (ibus_dat_i),
      .pc_fetch_i               (pc_if.pc_fetch),
      .decode_insn_o            (decode_insn_o),
      .pc_decode_o              (pc_decode_o),
      .decode_except_ibus_err_o (decode_except_ibus_err_o)
   );

endmodule

// ==== src/fetch_decode_reg.sv ====
// decode boundary register: instruction word, its PC and the sticky ibus error flag
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_decode_reg (
   input  logic             clk,
   input  logic             rst,
   input  logic             capture_i,
   input  logic             ibus_ack_i,
   input  logic             ibus_err_i,
   input  logic             du_restart_i,
   input  logic             err_clear_i,
   input  fetch_pkg::insn_t ibus_dat_i,
   input  fetch_pkg::pc_t   pc_fetch_i,
   output fetch_pkg::insn_t decode_insn_o,
   output fetch_pkg::pc_t   pc_decode_o,
   output logic             decode_except_ibus_err_o
);

   // instruction word, a NOP stands in for a faulted access
   always_ff @(posedge clk) begin
      if (capture_i & ibus_ack_i) begin
         decode_insn_o <= ibus_dat_i;
      end else if (capture_i & ibus_err_i) begin
         decode_insn_o <= `FETCH_NOP_INSN;
      end
   end

   // PC of the access that just completed
   always_ff @(posedge clk) begin
      if (capture_i) begin
         pc_decode_o <= pc_fetch_i;
      end
   end

   // sticky until a restart or an accepted branch
   always_ff @(posedge clk) begin
      if (rst) begin
         decode_except_ibus_err_o <= 1'b0;
      end else if (du_restart_i) begin
         decode_except_ibus_err_o <= 1'b0;
      end else if (capture_i & ibus_err_i) begin
         decode_except_ibus_err_o <= 1'b1;
      end else if (decode_except_ibus_err_o & err_clear_i) begin
         decode_except_ibus_err_o <= 1'b0;
      end
   end

endmodule

// ==== src/fetch_pc_counter.sv ====
// PC counter: lookahead address and in-flight fetch PC, updated by the FSM load commands
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_pc_counter (
   input  logic           clk,
   input  logic           rst,
   input  fetch_pkg::pc_t branch_dest_i,
   input  fetch_pkg::pc_t du_restart_pc_i,
   fetch_pc_if.pc         pc_bus
);

   fetch_pkg::pc_t pc_addr_q;
   fetch_pkg::pc_t pc_fetch_q;

   assign pc_bus.pc_addr  = pc_addr_q;
   assign pc_bus.pc_fetch = pc_fetch_q;

   // priority restart, branch, refetch, step, hold
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_addr_q  <= `FETCH_RESET_PC;
         pc_fetch_q <= `FETCH_RESET_PC;
      end else if (pc_bus.restart) begin
         // both restart at the new PC so the first access after the drain is clean
         pc_addr_q  <= du_restart_pc_i;
         pc_fetch_q <= du_restart_pc_i;
      end else if (pc_bus.branch) begin
         pc_addr_q  <= branch_dest_i;
         pc_fetch_q <= pc_addr_q;
      end else if (pc_bus.refetch) begin
         pc_addr_q <= pc_fetch_q;
      end else if (pc_bus.step) begin
         pc_addr_q  <= pc_addr_q + fetch_pkg::pc_t'(`FETCH_PC_STEP);
         pc_fetch_q <= pc_addr_q;
      end else if (pc_bus.hold_fetch) begin
         // re-branch, the access in flight keeps its PC
         pc_addr_q <= branch_dest_i;
      end
   end

   // aligned targets keep both PCs word aligned
   a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
      (branch_dest_i[1:0] == 2'b00 && du_restart_pc_i[1:0] == 2'b00 &&
       pc_addr_q[1:0] == 2'b00 && pc_fetch_q[1:0] == 2'b00) |=>
      (pc_addr_q[1:0] == 2'b00 && pc_fetch_q[1:0] == 2'b00));

endmodule

// ==== src/fetch_fsm.sv ====
// fetch FSM: drives the ibus request, PC load commands and the valid/branch-taken pulses
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_fsm (
   input  logic clk,
   input  logic rst,
   input  logic padv_i,
   input  logic branch_occur_i,
   input  logic du_restart_i,
   input  logic pipeline_flush_i,
   input  logic ibus_ack_i,
   input  logic ibus_err_i,
   output logic ibus_req_o,
   output logic fetch_valid_o,
   output logic fetch_branch_taken_o,
   output logic capture_o,
   output logic err_clear_o,
   fetch_pc_if.ctrl pc_bus
);

   fetch_pkg::fetch_state_e state_q;
   fetch_pkg::fetch_state_e state_d;
   fetch_pkg::fetch_state_e pre_stall_q;
   fetch_pkg::fetch_state_e pre_stall_d;

   // whether the access waited out in BRANCH_WAITBUS goes to decode
   logic branch_fetch_valid_q;
   logic branch_fetch_valid_d;
   logic branch_occur_q;
   logic branch_edge;
   logic bus_done;
   logic req_d;
   logic valid_d;
   logic taken_d;
   logic cmd_step;
   logic cmd_branch;
   logic cmd_restart;
   logic cmd_refetch;
   logic cmd_hold;

   assign bus_done    = ibus_ack_i | ibus_err_i;
   assign branch_edge = branch_occur_i & ~branch_occur_q;

   // decode register loads only on accesses that belong to the running stream
   assign capture_o = bus_done & padv_i &
                      (state_q != fetch_pkg::STALL) & (state_q != fetch_pkg::DU_RESTART);

   // a branch accepted this cycle clears a pending bus error flag
   assign err_clear_o = padv_i &
                        (((state_q == fetch_pkg::ADVANCE) & branch_occur_i) |
                         (((state_q == fetch_pkg::BRANCH) |
                           (state_q == fetch_pkg::BRANCH_DONE)) & branch_edge));

   assign pc_bus.step       = cmd_step;
   assign pc_bus.branch     = cmd_branch;
   assign pc_bus.restart    = cmd_restart;
   assign pc_bus.refetch    = cmd_refetch;
   assign pc_bus.hold_fetch = cmd_hold;

   always_comb begin
      state_d              = state_q;
      pre_stall_d          = pre_stall_q;
      branch_fetch_valid_d = branch_fetch_valid_q;
      req_d                = 1'b1;
      valid_d              = 1'b0;
      taken_d              = 1'b0;
      cmd_step             = 1'b0;
      cmd_branch           = 1'b0;
      cmd_restart          = 1'b0;
      cmd_refetch          = 1'b0;
      cmd_hold             = 1'b0;

      case (state_q)
         fetch_pkg::INIT: begin
            state_d = fetch_pkg::LOAD_REQ;
         end

         fetch_pkg::DU_RESTART: begin
            // keep the request low until the bus is quiet
            if (ibus_req_o | bus_done) begin
               req_d = 1'b0;
            end else begin
               state_d = fetch_pkg::LOAD_REQ;
            end
         end

         fetch_pkg::LOAD_REQ: begin
            if (pre_stall_q == fetch_pkg::ADVANCE || pre_stall_q == fetch_pkg::BRANCH_DONE) begin
               cmd_step = 1'b1;
               state_d  = pre_stall_q;
            end else begin
               // stalled in the middle of a branch, so start the branch over
               cmd_branch = 1'b1;
               state_d    = fetch_pkg::BRANCH;
            end
         end

         fetch_pkg::ADVANCE: begin
            if (branch_occur_i) begin
               if (bus_done) begin
                  valid_d    = 1'b1;
                  cmd_branch = 1'b1;
                  state_d    = fetch_pkg::BRANCH;
               end else begin
                  // access in flight is still on the old stream
                  branch_fetch_valid_d = 1'b1;
                  state_d              = fetch_pkg::BRANCH_WAITBUS;
               end
            end else if (bus_done) begin
               valid_d  = 1'b1;
               cmd_step = 1'b1;
            end
         end

         fetch_pkg::STALL: begin
            if (padv_i & ~ibus_req_o) begin
               cmd_refetch = 1'b1;
               state_d     = fetch_pkg::LOAD_REQ;
            end else if (bus_done | ~ibus_req_o) begin
               req_d = 1'b0;
            end
         end

         fetch_pkg::BRANCH_WAITBUS: begin
            if (bus_done) begin
               valid_d    = branch_fetch_valid_q;
               cmd_branch = 1'b1;
               state_d    = fetch_pkg::BRANCH;
            end
         end

         fetch_pkg::BRANCH: begin
            // the access completing here is thrown away
            if (branch_edge) begin
               branch_fetch_valid_d = 1'b0;
               if (bus_done) begin
                  cmd_hold = 1'b1;
               end else begin
                  state_d = fetch_pkg::BRANCH_WAITBUS;
               end
            end else if (bus_done) begin
               cmd_step = 1'b1;
               state_d  = fetch_pkg::BRANCH_DONE;
            end
         end

         fetch_pkg::BRANCH_DONE: begin
            // a second branch here, e.g. an exception right behind the first
            if (branch_edge) begin
               branch_fetch_valid_d = 1'b0;
               if (bus_done) begin
                  cmd_hold = 1'b1;
                  state_d  = fetch_pkg::BRANCH;
               end else begin
                  state_d = fetch_pkg::BRANCH_WAITBUS;
               end
            end else if (bus_done) begin
               valid_d  = 1'b1;
               taken_d  = 1'b1;
               cmd_step = 1'b1;
               state_d  = fetch_pkg::ADVANCE;
            end
         end

         default: begin
            state_d = fetch_pkg::INIT;
         end
      endcase

      // padv low freezes the PCs and remembers where to resume
      if (~padv_i && (state_q inside {fetch_pkg::ADVANCE, fetch_pkg::BRANCH_WAITBUS,
                                      fetch_pkg::BRANCH, fetch_pkg::BRANCH_DONE})) begin
         req_d       = ~bus_done;
         valid_d     = 1'b0;
         taken_d     = 1'b0;
         cmd_step    = 1'b0;
         cmd_branch  = 1'b0;
         cmd_refetch = 1'b0;
         cmd_hold    = 1'b0;
         pre_stall_d = state_q;
         state_d     = fetch_pkg::STALL;
      end

      // debug restart wins over everything else
      if (du_restart_i) begin
         req_d       = 1'b0;
         valid_d     = 1'b0;
         taken_d     = 1'b0;
         cmd_step    = 1'b0;
         cmd_branch  = 1'b0;
         cmd_refetch = 1'b0;
         cmd_hold    = 1'b0;
         cmd_restart = 1'b1;
         pre_stall_d = fetch_pkg::ADVANCE;
         state_d     = fetch_pkg::DU_RESTART;
      end

      if (pipeline_flush_i) begin
         valid_d = 1'b0;
         taken_d = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q              <= fetch_pkg::INIT;
         pre_stall_q          <= fetch_pkg::ADVANCE;
         branch_fetch_valid_q <= 1'b0;
         branch_occur_q       <= 1'b0;
         ibus_req_o           <= 1'b0;
         fetch_valid_o        <= 1'b0;
         fetch_branch_taken_o <= 1'b0;
      end else begin
         state_q              <= state_d;
         pre_stall_q          <= pre_stall_d;
         branch_fetch_valid_q <= branch_fetch_valid_d;
         branch_occur_q       <= branch_occur_i;
         ibus_req_o           <= req_d;
         fetch_valid_o        <= valid_d;
         fetch_branch_taken_o <= taken_d;
      end
   end

   // the PC counter resolves by priority, but the FSM never issues two loads at once
   a_one_load: assert property (@(posedge clk) disable iff (rst)
      $onehot0({cmd_step, cmd_branch, cmd_restart, cmd_refetch, cmd_hold}));

   // nothing reaches decode while the pipeline is held
   a_stall_quiet: assert property (@(posedge clk) disable iff (rst)
      (state_q == fetch_pkg::STALL && $past(~padv_i)) |-> ~fetch_valid_o);

   // in the streaming states the lookahead address runs one word ahead of the access
   a_pc_lookahead: assert property (@(posedge clk) disable iff (rst)
      (state_q == fetch_pkg::ADVANCE || state_q == fetch_pkg::BRANCH_DONE) |->
      (pc_bus.pc_addr == pc_bus.pc_fetch + fetch_pkg::pc_t'(`FETCH_PC_STEP)));

endmodule

// ==== src/fetch_pc_if.sv ====
// PC load commands from the fetch FSM to the PC counter, and the PC values coming back
`timescale 1ns/1ps

interface fetch_pc_if;

   // one-cycle load commands, at most one per cycle
   logic step;
   logic branch;
   logic restart;
   logic refetch;
   logic hold_fetch;

   // lookahead address and the address of the access in flight
   fetch_pkg::pc_t pc_addr;
   fetch_pkg::pc_t pc_fetch;

   modport ctrl (
      output step, branch, restart, refetch, hold_fetch,
      input  pc_addr, pc_fetch
   );

   modport pc (
      input  step, branch, restart, refetch, hold_fetch,
      output pc_addr, pc_fetch
   );

endinterface

// ==== src/fetch_pkg.sv ====
// shared types of the fetch stage; referenced by scoped name from every fetch module
`include "fetch_defs.svh"

package fetch_pkg;

   // instruction address
   typedef logic [`FETCH_XLEN-1:0] pc_t;

   // raw instruction word from the ibus
   typedef logic [`FETCH_INSN_WIDTH-1:0] insn_t;

   // fetch FSM states, also used for the saved pre-stall state
   typedef enum logic [2:0] {
      INIT           = 3'd0,
      DU_RESTART     = 3'd1,
      LOAD_REQ       = 3'd2,
      ADVANCE        = 3'd3,
      STALL          = 3'd4,
      BRANCH_WAITBUS = 3'd5,
      BRANCH         = 3'd6,
      BRANCH_DONE    = 3'd7
   } fetch_state_e;

endpackage

// ==== include/fetch_defs.svh ====
// fetch stage widths, reset PC, PC step and NOP encoding; include wherever these are needed
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// operand and address width
`define FETCH_XLEN 32

// instruction word width
`define FETCH_INSN_WIDTH 32

// first fetch address after reset
`define FETCH_RESET_PC 32'h0000_0100

// byte distance between sequential fetches
`define FETCH_PC_STEP 4

// NOP opcode with all fields zero, handed to decode on a bus error
`define FETCH_NOP_INSN 32'h1500_0000

`endif
